//--- list.f
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/core_top.sv
tb/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core -f list.f -o Vtb_core

out=$(./obj_dir/Vtb_core 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Simulation passed"; then
  exit 0
else
  exit 1
fi

//--- tb/tb_core.sv
`timescale 1ns/10ps

module tb_core;

  logic                        clk;
  logic                        rst_n;
  logic [rv_pkg::inst_w-1:0]   wb_dat_i;
  logic                        wb_ack;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic [rv_pkg::xlen-1:0]     wb_adr;
  logic                        wb_we;
  logic                        retire_valid;
  logic [rv_pkg::xlen-1:0]     retire_pc;
  logic [rv_pkg::reg_id_w-1:0] retire_rd;
  logic [rv_pkg::xlen-1:0]     retire_data;
  logic                        halted;
  logic                        illegal;

  // program image and run bookkeeping
  logic [rv_pkg::inst_w-1:0] prog [256];
  logic [rv_pkg::xlen-1:0]   model_regs [32];
  int   prog_len;
  int   halt_idx;
  logic expect_illegal;
  logic zero_wait;
  int   seed;
  int   wait_left;
  int   ret_idx;
  int   acc_count;
  int   fail_count;
  // bus checker state
  logic open_q;
  logic seen_cyc;
  logic bus_done;
  logic [rv_pkg::xlen-1:0] adr_q;

  core_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .wb_we        (wb_we),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted),
    .illegal      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    fail_count++;
    $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic fail_plain(input string msg);
    fail_count++;
    $display("t=%0t %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // instruction encoders for the add group
  function automatic logic [31:0] enc_i(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, rv_pkg::op_imm};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, rv_pkg::op_reg};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // reference model steps one instruction per call
  function automatic logic [63:0] ref_step(input logic [31:0] word, input logic [63:0] pc,
                                           output logic [4:0] exp_rd);
    logic [4:0]  rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] res;
    logic        wr;
    rd    = word[11:7];
    a     = model_regs[word[19:15]];
    b     = model_regs[word[24:20]];
    imm_i = {{52{word[31]}}, word[31:20]};
    imm_u = {{32{word[31]}}, word[31:12], 12'h000};
    wr    = 1'b1;
    res   = '0;
    case (word[6:0])
      rv_pkg::op_imm:   res = a + imm_i;
      // bit 30 picks sub
      rv_pkg::op_reg:   res = word[30] ? (a - b) : (a + b);
      rv_pkg::op_lui:   res = imm_u;
      rv_pkg::op_auipc: res = pc + imm_u;
      default:          wr = 1'b0;
    endcase
    if (wr && (rd != 5'd0)) begin
      model_regs[rd] = res;
    end
    exp_rd = wr ? rd : 5'd0;
    return (wr && (rd != 5'd0)) ? res : 64'd0;
  endfunction

  // out of range reads give an addi to x0
  function automatic logic [31:0] fetch_word(input logic [63:0] adr);
    logic [63:0] idx;
    logic [31:0] fold;
    idx = (adr - rv_pkg::reset_pc) >> 2;
    if ((adr >= rv_pkg::reset_pc) && (idx < 64'(prog_len))) begin
      return prog[idx[7:0]];
    end
    fold = adr[63:32] ^ adr[31:0];
    return {fold[31:20] ^ fold[19:8] ^ {fold[7:0], 4'h0}, 13'h0000, rv_pkg::op_imm};
  endfunction

  // prologue sets every register before the random body and the halt word
  task automatic build_program(input logic with_illegal);
    int n;
    int k;
    int body;
    int kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] prev_rd;
    n       = 0;
    prev_rd = 5'd0;
    for (k = 1; k < 32; k++) begin
      prog[n] = enc_i(5'(k), 5'd0, 12'($random(seed)));
      n++;
    end
    body = with_illegal ? 40 : 60;
    for (k = 0; k < body; k++) begin
      if (with_illegal && (k == body / 2)) begin
        // a load is not part of this core
        prog[n]  = 32'h0000_a503;
        halt_idx = n;
        n++;
      end
      rd  = 5'($random(seed));
      rs1 = 5'($random(seed));
      rs2 = 5'($random(seed));
      // x0 as target and as source now and then
      if ((k % 11) == 0) begin
        rd = 5'd0;
      end
      if ((k % 7) == 3) begin
        rs1 = 5'd0;
      end
      // back to back dependence
      if (($random(seed) & 1) != 0) begin
        rs1 = prev_rd;
      end
      kind = {$random(seed)} % 5;
      case (kind)
        0:       prog[n] = enc_i(rd, rs1, 12'($random(seed)));
        1:       prog[n] = enc_r(7'b0000000, rd, rs1, rs2);
        2:       prog[n] = enc_r(rv_pkg::funct7_sub, rd, rs1, rs2);
        3:       prog[n] = enc_u(rv_pkg::op_lui, rd, 20'($random(seed)));
        default: prog[n] = enc_u(rv_pkg::op_auipc, rd, 20'($random(seed)));
      endcase
      prev_rd = rd;
      n++;
    end
    prog[n] = rv_pkg::ebreak_word;
    if (!with_illegal) begin
      halt_idx = n;
    end
    n++;
    prog_len       = n;
    expect_illegal = with_illegal;
  endtask

  task automatic run_program(input logic no_wait);
    int cycles;
    int limit;
    int k;
    zero_wait = no_wait;
    rst_n <= 1'b0;
    repeat (5) @(posedge clk);
    ret_idx   = 0;
    acc_count = 0;
    open_q    = 1'b0;
    seen_cyc  = 1'b0;
    bus_done  = 1'b0;
    for (k = 0; k < 32; k++) begin
      model_regs[k] = '0;
    end
    rst_n <= 1'b1;
    limit  = prog_len * 8 + 100;
    cycles = 0;
    while (!halted) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        fail_plain("timeout, the core never halted");
      end
    end
    // nothing more may retire or fetch while idle
    repeat (20) @(posedge clk);
    assert (!wb_cyc) else fail_plain("wb_cyc is high again after the halt");
    assert (ret_idx == halt_idx + 1)
      else fail_value("retire count", 64'(halt_idx + 1), 64'(ret_idx));
    assert (illegal == expect_illegal)
      else fail_value("illegal", 64'(expect_illegal), 64'(illegal));
  endtask

  // wishbone slave with 0 to 3 wait states
  always @(posedge clk) begin : wb_slave
    if (!rst_n) begin
      wb_ack    <= 1'b0;
      wait_left <= 0;
    end else if (wb_ack && zero_wait && wb_cyc) begin
      // next word follows at once while cyc stays up
      wb_dat_i <= fetch_word(wb_adr + 64'd4);
    end else if (wb_ack) begin
      wb_ack    <= 1'b0;
      wait_left <= zero_wait ? 0 : ({$random(seed)} % 4);
    end else if (wb_cyc && wb_stb) begin
      if (wait_left == 0) begin
        wb_ack   <= 1'b1;
        wb_dat_i <= fetch_word(wb_adr);
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

  // bus protocol checks
  always @(posedge clk) begin : check_bus
    if (rst_n) begin
      assert (!wb_we) else fail_plain("wb_we went high on the read-only bus");
      assert (wb_stb == wb_cyc) else fail_value("wb_stb", 64'(wb_cyc), 64'(wb_stb));
      if (wb_cyc) begin
        assert (!bus_done) else fail_plain("a new bus cycle started after the core stopped");
        seen_cyc = 1'b1;
        // address held while waiting
        if (open_q) begin
          assert (wb_adr == adr_q) else fail_value("wb_adr", adr_q, wb_adr);
        end
        if (wb_ack) begin
          assert (wb_adr == rv_pkg::reset_pc + 64'(acc_count) * 64'd4)
            else fail_value("wb_adr", rv_pkg::reset_pc + 64'(acc_count) * 64'd4, wb_adr);
          acc_count++;
          open_q = 1'b0;
        end else begin
          open_q = 1'b1;
          adr_q  = wb_adr;
        end
      end else begin
        // the bus stays idle until reset once dropped
        if (seen_cyc) begin
          bus_done = 1'b1;
        end
        open_q = 1'b0;
      end
    end
  end

  // retire trace against the model
  always @(posedge clk) begin : compare_retire
    logic [63:0] exp_pc;
    logic [63:0] exp_data;
    logic [4:0]  exp_rd;
    if (rst_n && retire_valid) begin
      assert (ret_idx <= halt_idx)
        else fail_plain("an instruction retired after the halting word");
      exp_pc   = rv_pkg::reset_pc + 64'(ret_idx) * 64'd4;
      exp_data = ref_step(prog[ret_idx], exp_pc, exp_rd);
      assert (retire_pc == exp_pc) else fail_value("retire_pc", exp_pc, retire_pc);
      assert (retire_rd == exp_rd) else fail_value("retire_rd", 64'(exp_rd), 64'(retire_rd));
      assert (retire_data == exp_data) else fail_value("retire_data", exp_data, retire_data);
      ret_idx++;
    end
  end

  initial begin
    seed       = 32'h4e75;
    fail_count = 0;
    rst_n      = 1'b0;
    wb_ack     = 1'b0;
    wb_dat_i   = '0;
    zero_wait  = 1'b0;
    prog_len   = 0;
    halt_idx   = 0;
    // random waits and a final ebreak
    build_program(1'b0);
    run_program(1'b0);
    // zero waits with an illegal word in the middle
    build_program(1'b1);
    run_program(1'b1);
    if (fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

//--- logic/core_top.sv
`timescale 1ns/10ps

module core_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [rv_pkg::inst_w-1:0]    wb_dat_i,
  input  logic                         wb_ack,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic [rv_pkg::xlen-1:0]      wb_adr,
  output logic                         wb_we,
  output logic                         retire_valid,
  output logic [rv_pkg::xlen-1:0]      retire_pc,
  output logic [rv_pkg::reg_id_w-1:0]  retire_rd,
  output logic [rv_pkg::xlen-1:0]      retire_data,
  output logic                         halted,
  output logic                         illegal
);

  // fetch to decode
  logic                        stop;
  logic                        f_valid;
  logic [rv_pkg::inst_w-1:0]   f_inst;
  logic [rv_pkg::xlen-1:0]     f_pc;
  // register file ports
  logic [rv_pkg::reg_id_w-1:0] rs1;
  logic [rv_pkg::reg_id_w-1:0] rs2;
  logic [rv_pkg::xlen-1:0]     rdata_1;
  logic [rv_pkg::xlen-1:0]     rdata_2;
  logic                        wen;
  logic [rv_pkg::reg_id_w-1:0] rd;
  logic [rv_pkg::xlen-1:0]     wdata;
  // decode to execute
  logic                        d_valid;
  logic [rv_pkg::xlen-1:0]     d_pc;
  logic [rv_pkg::reg_id_w-1:0] d_rd;
  logic                        d_op1_src_pc;
  logic                        d_use_imm;
  logic                        d_sub;
  logic [rv_pkg::xlen-1:0]     d_rs1_val;
  logic [rv_pkg::xlen-1:0]     d_rs2_val;
  logic [rv_pkg::xlen-1:0]     d_imm;
  logic                        d_wen;
  logic                        d_ebreak;
  logic                        d_illegal;

  // instruction port is read only
  assign wb_we = 1'b0;

  fetch_stage u_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .stop     (stop),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .f_valid  (f_valid),
    .f_inst   (f_inst),
    .f_pc     (f_pc)
  );

  decode_stage u_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .f_valid      (f_valid),
    .f_inst       (f_inst),
    .f_pc         (f_pc),
    .rdata_1      (rdata_1),
    .rdata_2      (rdata_2),
    .rs1          (rs1),
    .rs2          (rs2),
    .stop         (stop),
    .d_valid      (d_valid),
    .d_pc         (d_pc),
    .d_rd         (d_rd),
    .d_op1_src_pc (d_op1_src_pc),
    .d_use_imm    (d_use_imm),
    .d_sub        (d_sub),
    .d_rs1_val    (d_rs1_val),
    .d_rs2_val    (d_rs2_val),
    .d_imm        (d_imm),
    .d_wen        (d_wen),
    .d_ebreak     (d_ebreak),
    .d_illegal    (d_illegal)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .wen     (wen),
    .rd      (rd),
    .wdata   (wdata),
    .rs1     (rs1),
    .rs2     (rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  execute_stage u_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .d_valid      (d_valid),
    .d_pc         (d_pc),
    .d_rd         (d_rd),
    .d_op1_src_pc (d_op1_src_pc),
    .d_use_imm    (d_use_imm),
    .d_sub        (d_sub),
    .d_rs1_val    (d_rs1_val),
    .d_rs2_val    (d_rs2_val),
    .d_imm        (d_imm),
    .d_wen        (d_wen),
    .d_ebreak     (d_ebreak),
    .d_illegal    (d_illegal),
    .wen          (wen),
    .rd           (rd),
    .wdata        (wdata),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted),
    .illegal      (illegal)
  );

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         d_valid,
  input  logic [rv_pkg::xlen-1:0]      d_pc,
  input  logic [rv_pkg::reg_id_w-1:0]  d_rd,
  input  logic                         d_op1_src_pc,
  input  logic                         d_use_imm,
  input  logic                         d_sub,
  input  logic [rv_pkg::xlen-1:0]      d_rs1_val,
  input  logic [rv_pkg::xlen-1:0]      d_rs2_val,
  input  logic [rv_pkg::xlen-1:0]      d_imm,
  input  logic                         d_wen,
  input  logic                         d_ebreak,
  input  logic                         d_illegal,
  output logic                         wen,
  output logic [rv_pkg::reg_id_w-1:0]  rd,
  output logic [rv_pkg::xlen-1:0]      wdata,
  output logic                         retire_valid,
  output logic [rv_pkg::xlen-1:0]      retire_pc,
  output logic [rv_pkg::reg_id_w-1:0]  retire_rd,
  output logic [rv_pkg::xlen-1:0]      retire_data,
  output logic                         halted,
  output logic                         illegal
);

  logic [rv_pkg::xlen-1:0] op1;
  logic [rv_pkg::xlen-1:0] op2;
  logic [rv_pkg::xlen-1:0] result;
  // register actually changes, x0 excluded
  logic writes_reg;

  // auipc takes the pc, everything else rs1 (x0 for lui)
  assign op1    = d_op1_src_pc ? d_pc : d_rs1_val;
  assign op2    = d_use_imm ? d_imm : d_rs2_val;
  assign result = d_sub ? (op1 - op2) : (op1 + op2);

  // write back at the end of the d_valid cycle
  assign wen        = d_valid & d_wen;
  assign rd         = d_rd;
  assign wdata      = result;
  assign writes_reg = wen & (d_rd != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
      halted       <= 1'b0;
      illegal      <= 1'b0;
    end else begin
      retire_valid <= d_valid;
      // sticky until reset
      if (d_valid && (d_ebreak || d_illegal)) begin
        halted <= 1'b1;
      end
      if (d_valid && d_illegal) begin
        illegal <= 1'b1;
      end
    end
  end

  // trace payload
  always_ff @(posedge clk) begin
    if (d_valid) begin
      retire_pc   <= d_pc;
      // ebreak and illegal report no destination
      retire_rd   <= d_wen ? d_rd : '0;
      // x0 target reads back zero
      retire_data <= writes_reg ? result : '0;
    end
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                         clk,
  input  logic                         wen,
  input  logic [rv_pkg::reg_id_w-1:0]  rd,
  input  logic [rv_pkg::xlen-1:0]      wdata,
  input  logic [rv_pkg::reg_id_w-1:0]  rs1,
  input  logic [rv_pkg::reg_id_w-1:0]  rs2,
  output logic [rv_pkg::xlen-1:0]      rdata_1,
  output logic [rv_pkg::xlen-1:0]      rdata_2
);

  // entry 0 is never written
  logic [rv_pkg::xlen-1:0] regs [32];

  // x0 reads zero and a pending write is bypassed
  function automatic logic [rv_pkg::xlen-1:0] read_port(
    input logic [rv_pkg::reg_id_w-1:0] sel
  );
    if (sel == '0) begin
      return '0;
    end else if (wen && (rd == sel)) begin
      return wdata;
    end
    return regs[sel];
  endfunction

  // async read on both ports
  always_comb begin
    rdata_1 = read_port(rs1);
    rdata_2 = read_port(rs2);
  end

  // writes to x0 are dropped
  always_ff @(posedge clk) begin
    if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         f_valid,
  input  logic [rv_pkg::inst_w-1:0]    f_inst,
  input  logic [rv_pkg::xlen-1:0]      f_pc,
  input  logic [rv_pkg::xlen-1:0]      rdata_1,
  input  logic [rv_pkg::xlen-1:0]      rdata_2,
  output logic [rv_pkg::reg_id_w-1:0]  rs1,
  output logic [rv_pkg::reg_id_w-1:0]  rs2,
  output logic                         stop,
  output logic                         d_valid,
  output logic [rv_pkg::xlen-1:0]      d_pc,
  output logic [rv_pkg::reg_id_w-1:0]  d_rd,
  output logic                         d_op1_src_pc,
  output logic                         d_use_imm,
  output logic                         d_sub,
  output logic [rv_pkg::xlen-1:0]      d_rs1_val,
  output logic [rv_pkg::xlen-1:0]      d_rs2_val,
  output logic [rv_pkg::xlen-1:0]      d_imm,
  output logic                         d_wen,
  output logic                         d_ebreak,
  output logic                         d_illegal
);

  rv_pkg::inst_t inst;
  logic is_addi;
  logic is_reg;
  logic is_sub;
  logic is_lui;
  logic is_auipc;
  logic is_ebreak;
  logic is_illegal;
  logic [rv_pkg::xlen-1:0] imm;
  // sticky halt request
  logic stop_q;
  // word is passed on to execute
  logic take;

  assign inst = f_inst;

  // opcode and funct fields sit in the same place in every view
  assign is_addi  = (inst.i.opcode == rv_pkg::op_imm) && (inst.i.funct3 == rv_pkg::funct3_add);
  assign is_sub   = (inst.r.funct7 == rv_pkg::funct7_sub);
  assign is_reg   = (inst.r.opcode == rv_pkg::op_reg) &&
                    (inst.r.funct3 == rv_pkg::funct3_add) &&
                    ((inst.r.funct7 == rv_pkg::funct7_add) || is_sub);
  assign is_lui   = (inst.u.opcode == rv_pkg::op_lui);
  assign is_auipc = (inst.u.opcode == rv_pkg::op_auipc);
  // only the exact encoding counts, any other system word is illegal
  assign is_ebreak  = (f_inst == rv_pkg::ebreak_word);
  assign is_illegal = ~(is_addi | is_reg | is_lui | is_auipc | is_ebreak);

  // i-type sign extends imm12, u-type puts imm20 at bit 12
  always_comb begin
    if (is_lui || is_auipc) begin
      imm = {{(rv_pkg::xlen - 32){inst.u.imm20[19]}}, inst.u.imm20, 12'b0};
    end else begin
      imm = {{(rv_pkg::xlen - 12){inst.i.imm12[11]}}, inst.i.imm12};
    end
  end

  // lui adds its immediate to x0
  assign rs1 = is_lui ? '0 : inst.r.rs1;
  assign rs2 = inst.r.rs2;

  // raised in the same cycle the halting word shows up
  assign stop = stop_q | (f_valid & (is_ebreak | is_illegal));
  // anything behind a halt is dropped
  assign take = f_valid & ~stop_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stop_q  <= 1'b0;
      d_valid <= 1'b0;
    end else begin
      stop_q  <= stop;
      d_valid <= take;
    end
  end

  // operands and controls for execute
  always_ff @(posedge clk) begin
    if (take) begin
      d_pc         <= f_pc;
      d_rd         <= inst.r.rd;
      d_op1_src_pc <= is_auipc;
      // only register-register ops use rs2
      d_use_imm    <= ~is_reg;
      d_sub        <= is_reg & is_sub;
      d_rs1_val    <= rdata_1;
      d_rs2_val    <= rdata_2;
      d_imm        <= imm;
      d_wen        <= is_addi | is_reg | is_lui | is_auipc;
      d_ebreak     <= is_ebreak;
      d_illegal    <= is_illegal;
    end
  end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       stop,
  input  logic [rv_pkg::inst_w-1:0]  wb_dat_i,
  input  logic                       wb_ack,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic [rv_pkg::xlen-1:0]    wb_adr,
  output logic                       f_valid,
  output logic [rv_pkg::inst_w-1:0]  f_inst,
  output logic [rv_pkg::xlen-1:0]    f_pc
);

  // program counter, address of the word being requested
  logic [rv_pkg::xlen-1:0] pc;
  // bus request armed, low in reset and forever after stop
  logic req_q;
  // word taken from the slave this cycle
  logic accept;

  // stop drops the bus in the same cycle
  assign wb_cyc = req_q & ~stop;
  // classic cycle, strobe follows cyc
  assign wb_stb = wb_cyc;
  assign wb_adr = pc;

  // late ack after stop is ignored
  assign accept = wb_cyc & wb_ack;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q   <= 1'b0;
      pc      <= rv_pkg::reset_pc;
      f_valid <= 1'b0;
    end else begin
      f_valid <= accept;
      if (stop) begin
        // idle for good, decode holds stop until reset
        req_q <= 1'b0;
      end else begin
        // next request starts right after the ack
        req_q <= 1'b1;
      end
      if (accept) begin
        pc <= pc + rv_pkg::xlen'(4);
      end
    end
  end

  // payload, only loaded with a fresh word
  always_ff @(posedge clk) begin
    if (accept) begin
      f_inst <= wb_dat_i;
      f_pc   <= pc;
    end
  end

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

  // machine widths
  localparam int xlen     = 64;
  localparam int reg_id_w = 5;
  localparam int inst_w   = 32;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 64'h8000_0000;

  // major opcodes, bits [6:0]
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct codes for the add family
  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [6:0] funct7_add = 7'b0000000;
  // bit 30 set turns add into sub
  localparam logic [6:0] funct7_sub = 7'b0100000;

  // the one system word we accept
  localparam logic [inst_w-1:0] ebreak_word = 32'h0010_0073;

  // one instruction word, three field layouts
  typedef union packed {
    // register-register
    struct packed {
      logic [6:0]          funct7;
      logic [reg_id_w-1:0] rs2;
      logic [reg_id_w-1:0] rs1;
      logic [2:0]          funct3;
      logic [reg_id_w-1:0] rd;
      logic [6:0]          opcode;
    } r;
    // register-immediate
    struct packed {
      logic [11:0]         imm12;
      logic [reg_id_w-1:0] rs1;
      logic [2:0]          funct3;
      logic [reg_id_w-1:0] rd;
      logic [6:0]          opcode;
    } i;
    // upper immediate
    struct packed {
      logic [19:0]         imm20;
      logic [reg_id_w-1:0] rd;
      logic [6:0]          opcode;
    } u;
  } inst_t;

endpackage
